// File: f8_pkg.sv
package f8_pkg;

	localparam int ADDR_W = 16;
	localparam int BANK_ADDR_W = 15;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

	// opcode in [7:0], immediate or displacement in [15:8], direct address in [23:8]
	typedef logic [23:0] inst_t;

	typedef enum logic [7:0]
	{
		NOP = 8'h00,
		TRAP = 8'h01,
		LD_XL_IMMD = 8'h10,
		LD_XL_DIR = 8'h11,
		LD_DIR_XL = 8'h12,
		ADD_XL_IMMD = 8'h20,
		SUB_XL_IMMD = 8'h21,
		AND_XL_IMMD = 8'h22,
		OR_XL_IMMD = 8'h23,
		XOR_XL_IMMD = 8'h24,
		ADD_XL_DIR = 8'h28,
		LDW_Y_IMMD = 8'h30,
		INCW_Y = 8'h31,
		LDW_DIR_Y = 8'h32,
		JR_D = 8'h40,
		JRZ_D = 8'h41,
		JRNZ_D = 8'h42,
		JRC_D = 8'h43
	} opcode_t;

	// bits 5 to 7 of f are always zero
	typedef enum logic [2:0]
	{
		FLAG_H,
		FLAG_C,
		FLAG_N,
		FLAG_Z,
		FLAG_O
	} flag_pos_t;

	localparam word_t RESET_PC = 16'h4000;
	localparam word_t RESET_SP = 16'h0000;

	typedef enum logic [1:0]
	{
		REG_X = 2'd0,
		REG_Y = 2'd1,
		REG_Z = 2'd2
	} reg_sel_t;

	// be[0] is the low byte
	typedef struct packed
	{
		reg_sel_t sel;
		word_t data;
		logic [1:0] be;
	} reg_write_t;

	typedef struct packed
	{
		logic [ADDR_W-1:0] addr;
		word_t data;
		logic [1:0] be;
	} mem_write_t;

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	typedef struct packed
	{
		logic h;
		logic c;
		logic n;
		logic z;
		logic o;
	} alu_flags_t;

	function automatic logic [1:0] opcode_size(opcode_t op);
		case (op)
			LD_XL_IMMD, ADD_XL_IMMD, SUB_XL_IMMD, AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD,
			JR_D, JRZ_D, JRNZ_D, JRC_D:
				return 2'd2;
			LD_XL_DIR, LD_DIR_XL, ADD_XL_DIR, LDW_Y_IMMD, LDW_DIR_Y:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

	function automatic logic opcode_loads_upper(opcode_t op);
		return opcode_size(op) == 2'd3;
	endfunction

	function automatic logic opcode_loads_operand(opcode_t op);
		return op == LD_XL_DIR || op == ADD_XL_DIR;
	endfunction

endpackage

// File: f8_alu.sv
module f8_alu import f8_pkg::*; #(
	parameter type data_t = byte_t
) (
	input alu_op_t op,
	input data_t a,
	input data_t b,
	output data_t result,
	output alu_flags_t flags
);
	data_t b_in;
	logic carry_in;
	logic [$bits(data_t):0] sum;
	logic [4:0] low_sum;

	// subtract as a + ~b + 1
	assign carry_in = (op == ALU_SUB);
	assign b_in = carry_in ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, b_in} + carry_in;
	assign low_sum = {1'b0, a[3:0]} + {1'b0, b_in[3:0]} + 5'(carry_in);

	always_comb
	begin
		flags = '0;
		case (op)
			ALU_ADD, ALU_SUB:
			begin
				result = sum[$bits(data_t)-1:0];
				flags.c = sum[$bits(data_t)];
				flags.h = low_sum[4];
				flags.o = (a[$bits(data_t)-1] == b_in[$bits(data_t)-1]) &&
					(result[$bits(data_t)-1] != a[$bits(data_t)-1]);
			end
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			default:
				result = a;
		endcase
		flags.z = (result == '0);
		flags.n = result[$bits(data_t)-1];
	end

endmodule

// File: f8_regfile.sv
module f8_regfile import f8_pkg::*; (
	input logic clk,
	input logic reset,
	input reg_write_t wr,
	input byte_t next_f,
	input word_t next_pc,
	output word_t x,
	output word_t y,
	output word_t z,
	output byte_t f,
	output word_t sp,
	output word_t pc
);
	word_t gpr [3];

	assign x = gpr[REG_X];
	assign y = gpr[REG_Y];
	assign z = gpr[REG_Z];

	// byte lanes written independently
	always_ff @(posedge clk)
	begin
		if (wr.be[0])
			gpr[wr.sel][7:0] <= wr.data[7:0];
		if (wr.be[1])
			gpr[wr.sel][15:8] <= wr.data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			f <= '0;
			sp <= RESET_SP;
			pc <= RESET_PC;
		end
		else
		begin
			f <= {3'b000, next_f[4:0]};
			pc <= next_pc;
		end
	end

	a_no_fourth_reg: assert property (@(posedge clk) disable iff (reset)
		(|wr.be) |-> (wr.sel != 2'd3));

endmodule

// File: f8_mem_lanes.sv
module f8_mem_lanes import f8_pkg::*; (
	input logic clk,
	input word_t mem_read_addr,
	input mem_write_t mem_wr,
	input byte_t rd_data_even,
	input byte_t rd_data_odd,
	output bank_addr_t rd_addr_even,
	output bank_addr_t rd_addr_odd,
	output bank_addr_t wr_addr_even,
	output bank_addr_t wr_addr_odd,
	output byte_t wr_data_even,
	output byte_t wr_data_odd,
	output logic wr_en_even,
	output logic wr_en_odd,
	output byte_t rd_lo_first,
	output byte_t rd_hi_first
);
	bank_addr_t rd_word;
	bank_addr_t wr_word;
	logic wr_odd;
	logic rd_odd_q;

	// odd start: second byte sits in the next even word
	assign rd_word = mem_read_addr[ADDR_W-1:1];
	assign rd_addr_odd = rd_word;
	assign rd_addr_even = mem_read_addr[0] ? rd_word + BANK_ADDR_W'(1) : rd_word;

	assign wr_word = mem_wr.addr[ADDR_W-1:1];
	assign wr_odd = mem_wr.addr[0];
	assign wr_addr_odd = wr_word;
	assign wr_addr_even = wr_odd ? wr_word + BANK_ADDR_W'(1) : wr_word;
	assign wr_data_even = wr_odd ? mem_wr.data[15:8] : mem_wr.data[7:0];
	assign wr_data_odd = wr_odd ? mem_wr.data[7:0] : mem_wr.data[15:8];
	assign wr_en_even = wr_odd ? mem_wr.be[1] : mem_wr.be[0];
	assign wr_en_odd = wr_odd ? mem_wr.be[0] : mem_wr.be[1];

	// data comes back a cycle later
	always_ff @(posedge clk)
	begin
		rd_odd_q <= mem_read_addr[0];
	end

	assign rd_lo_first = rd_odd_q ? rd_data_odd : rd_data_even;
	assign rd_hi_first = rd_odd_q ? rd_data_even : rd_data_odd;

	a_wr_addr_known: assert property (@(posedge clk)
		(|mem_wr.be) |-> !$isunknown(mem_wr.addr));

endmodule

// File: f8_fetch.sv
module f8_fetch import f8_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t pc,
	input byte_t rd_lo_first,
	input byte_t rd_hi_first,
	input logic branch_taken,
	output word_t mem_read_addr,
	output word_t next_pc,
	output inst_t inst,
	output word_t memop,
	output logic execute
);
	inst_t saved;
	logic rd_valid;
	logic upper_pend;
	logic operand_pend;
	logic load_upper;
	logic load_operand;
	opcode_t opcode;
	word_t target;

	// fresh bytes, or saved bytes plus the upper byte
	always_comb
	begin
		if (operand_pend)
			inst = saved;
		else if (upper_pend)
			inst = {rd_lo_first, saved[15:0]};
		else
			inst = {8'h00, rd_hi_first, rd_lo_first};
	end

	assign opcode = opcode_t'(inst[7:0]);
	assign memop = {rd_hi_first, rd_lo_first};

	assign load_upper = rd_valid && !upper_pend && !operand_pend && opcode_loads_upper(opcode);
	assign load_operand = upper_pend && opcode_loads_operand(opcode);
	assign execute = rd_valid && !load_upper && !load_operand;

	assign target = pc + {{8{inst[15]}}, inst[15:8]};

	always_comb
	begin
		if (!execute || opcode == TRAP)
			next_pc = pc;
		else if (branch_taken)
			next_pc = target;
		else
			next_pc = pc + word_t'(opcode_size(opcode));
	end

	always_comb
	begin
		if (load_upper)
			mem_read_addr = pc + 16'd2;
		else if (load_operand)
			mem_read_addr = inst[23:8];
		else
			mem_read_addr = next_pc;
	end

	// rd_valid low means the first read is still in flight
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_valid <= 1'b0;
			upper_pend <= 1'b0;
			operand_pend <= 1'b0;
		end
		else
		begin
			rd_valid <= 1'b1;
			upper_pend <= load_upper;
			operand_pend <= load_operand;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_upper || load_operand)
			saved <= inst;
	end

	a_one_pending: assert property (@(posedge clk) disable iff (reset)
		!(upper_pend && operand_pend));

endmodule

// File: f8_execute.sv
module f8_execute import f8_pkg::*; (
	input logic execute,
	input inst_t inst,
	input word_t memop,
	input word_t x,
	input word_t y,
	input byte_t f,
	output reg_write_t reg_wr,
	output mem_write_t mem_wr,
	output byte_t next_f,
	output logic branch_taken,
	output logic trap
);
	opcode_t opcode;
	alu_op_t op8;
	byte_t b8;
	byte_t res8;
	word_t res16;
	alu_flags_t fl8;
	alu_flags_t fl16;

	assign opcode = opcode_t'(inst[7:0]);

	always_comb
	begin
		case (opcode)
			SUB_XL_IMMD:
				op8 = ALU_SUB;
			AND_XL_IMMD:
				op8 = ALU_AND;
			OR_XL_IMMD:
				op8 = ALU_OR;
			XOR_XL_IMMD:
				op8 = ALU_XOR;
			default:
				op8 = ALU_ADD;
		endcase
	end

	assign b8 = (opcode == ADD_XL_DIR) ? memop[7:0] : inst[15:8];

	f8_alu #(.data_t(byte_t)) alu8 (.op(op8), .a(x[7:0]), .b(b8), .result(res8), .flags(fl8));

	// only incw uses the word unit
	f8_alu #(.data_t(word_t)) alu16 (.op(ALU_ADD), .a(y), .b(word_t'(1)), .result(res16),
		.flags(fl16));

	always_comb
	begin
		reg_wr = '{sel: REG_X, data: '0, be: 2'b00};
		mem_wr = '{addr: '0, data: '0, be: 2'b00};
		next_f = f;
		if (execute)
		begin
			case (opcode)
				LD_XL_IMMD:
					reg_wr = '{sel: REG_X, data: {8'h00, inst[15:8]}, be: 2'b01};
				LD_XL_DIR:
				begin
					reg_wr = '{sel: REG_X, data: {8'h00, memop[7:0]}, be: 2'b01};
					next_f[FLAG_Z] = (memop[7:0] == 8'h00);
					next_f[FLAG_N] = memop[7];
				end
				ADD_XL_IMMD, SUB_XL_IMMD, ADD_XL_DIR:
				begin
					reg_wr = '{sel: REG_X, data: {8'h00, res8}, be: 2'b01};
					next_f[FLAG_H] = fl8.h;
					next_f[FLAG_C] = fl8.c;
					next_f[FLAG_N] = fl8.n;
					next_f[FLAG_Z] = fl8.z;
					next_f[FLAG_O] = fl8.o;
				end
				AND_XL_IMMD, OR_XL_IMMD, XOR_XL_IMMD:
				begin
					reg_wr = '{sel: REG_X, data: {8'h00, res8}, be: 2'b01};
					next_f[FLAG_N] = fl8.n;
					next_f[FLAG_Z] = fl8.z;
				end
				LDW_Y_IMMD:
				begin
					reg_wr = '{sel: REG_Y, data: inst[23:8], be: 2'b11};
					next_f[FLAG_Z] = (inst[23:8] == 16'h0000);
					next_f[FLAG_N] = inst[23];
				end
				INCW_Y:
				begin
					// h is left alone for word ops
					reg_wr = '{sel: REG_Y, data: res16, be: 2'b11};
					next_f[FLAG_C] = fl16.c;
					next_f[FLAG_N] = fl16.n;
					next_f[FLAG_Z] = fl16.z;
					next_f[FLAG_O] = fl16.o;
				end
				LD_DIR_XL:
					mem_wr = '{addr: inst[23:8], data: {8'h00, x[7:0]}, be: 2'b01};
				LDW_DIR_Y:
					mem_wr = '{addr: inst[23:8], data: y, be: 2'b11};
				default:
				begin
				end
			endcase
		end
	end

	always_comb
	begin
		case (opcode)
			JR_D:
				branch_taken = execute;
			JRZ_D:
				branch_taken = execute && f[FLAG_Z];
			JRNZ_D:
				branch_taken = execute && !f[FLAG_Z];
			JRC_D:
				branch_taken = execute && f[FLAG_C];
			default:
				branch_taken = 1'b0;
		endcase
	end

	assign trap = execute && (opcode == TRAP);

endmodule

// File: f8_core.sv
module f8_core import f8_pkg::*; (
	input logic clk,
	input logic reset,
	output bank_addr_t mem_read_addr_even,
	input byte_t mem_read_data_even,
	output bank_addr_t mem_write_addr_even,
	output byte_t mem_write_data_even,
	output logic mem_write_en_even,
	output bank_addr_t mem_read_addr_odd,
	input byte_t mem_read_data_odd,
	output bank_addr_t mem_write_addr_odd,
	output byte_t mem_write_data_odd,
	output logic mem_write_en_odd,
	output logic trap
);
	word_t x;
	word_t y;
	byte_t f;
	byte_t next_f;
	word_t pc;
	word_t next_pc;
	reg_write_t reg_wr;
	mem_write_t mem_wr;
	word_t mem_read_addr;
	byte_t rd_lo_first;
	byte_t rd_hi_first;
	inst_t inst;
	word_t memop;
	logic execute;
	logic branch_taken;

	f8_regfile regs (.clk(clk), .reset(reset), .wr(reg_wr), .next_f(next_f),
		.next_pc(next_pc), .x(x), .y(y), .z(), .f(f), .sp(), .pc(pc));

	f8_mem_lanes lanes (.clk(clk), .mem_read_addr(mem_read_addr), .mem_wr(mem_wr),
		.rd_data_even(mem_read_data_even), .rd_data_odd(mem_read_data_odd),
		.rd_addr_even(mem_read_addr_even), .rd_addr_odd(mem_read_addr_odd),
		.wr_addr_even(mem_write_addr_even), .wr_addr_odd(mem_write_addr_odd),
		.wr_data_even(mem_write_data_even), .wr_data_odd(mem_write_data_odd),
		.wr_en_even(mem_write_en_even), .wr_en_odd(mem_write_en_odd),
		.rd_lo_first(rd_lo_first), .rd_hi_first(rd_hi_first));

	f8_fetch fetch (.clk(clk), .reset(reset), .pc(pc), .rd_lo_first(rd_lo_first),
		.rd_hi_first(rd_hi_first), .branch_taken(branch_taken),
		.mem_read_addr(mem_read_addr), .next_pc(next_pc), .inst(inst), .memop(memop),
		.execute(execute));

	f8_execute exec (.execute(execute), .inst(inst), .memop(memop), .x(x), .y(y), .f(f),
		.reg_wr(reg_wr), .mem_wr(mem_wr), .next_f(next_f), .branch_taken(branch_taken),
		.trap(trap));

endmodule

// File: f8_tb_mem.sv
module f8_tb_mem import f8_pkg::*; (
	input logic clk,
	input bank_addr_t rd_addr_even,
	input bank_addr_t rd_addr_odd,
	output byte_t rd_data_even,
	output byte_t rd_data_odd,
	input bank_addr_t wr_addr_even,
	input bank_addr_t wr_addr_odd,
	input byte_t wr_data_even,
	input byte_t wr_data_odd,
	input logic wr_en_even,
	input logic wr_en_odd
);
	timeunit 1ns;
	timeprecision 1ps;

	byte_t even_bank [2**BANK_ADDR_W];
	byte_t odd_bank [2**BANK_ADDR_W];

	initial
	begin
		rd_data_even = 8'h00;
		rd_data_odd = 8'h00;
	end

	// data one clock after the address, writes on the strobe
	always @(posedge clk)
	begin
		rd_data_even <= even_bank[rd_addr_even];
		rd_data_odd <= odd_bank[rd_addr_odd];
		if (wr_en_even)
			even_bank[wr_addr_even] <= wr_data_even;
		if (wr_en_odd)
			odd_bank[wr_addr_odd] <= wr_data_odd;
	end

	function automatic byte_t fill_byte(input word_t addr);
		return addr[7:0] ^ addr[15:8] ^ 8'h96;
	endfunction

	task automatic fill();
		for (int i = 0; i < 2**BANK_ADDR_W; i++)
		begin
			even_bank[i] = fill_byte({i[14:0], 1'b0});
			odd_bank[i] = fill_byte({i[14:0], 1'b1});
		end
	endtask

	task automatic load_byte(input word_t addr, input byte_t data);
		if (addr[0])
			odd_bank[addr[15:1]] = data;
		else
			even_bank[addr[15:1]] = data;
	endtask

	function automatic byte_t peek(input word_t addr);
		return addr[0] ? odd_bank[addr[15:1]] : even_bank[addr[15:1]];
	endfunction

endmodule

// File: f8_tb.sv
module f8_tb import f8_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NT = 16;
	localparam int MAX_BYTES = 16;
	localparam int RESET_CYCLES = 2;
	localparam int HOLD_CYCLES = 20;

	logic clk;
	logic reset;
	logic trap;
	bank_addr_t rd_addr_even;
	bank_addr_t rd_addr_odd;
	bank_addr_t wr_addr_even;
	bank_addr_t wr_addr_odd;
	byte_t rd_data_even;
	byte_t rd_data_odd;
	byte_t wr_data_even;
	byte_t wr_data_odd;
	logic wr_en_even;
	logic wr_en_odd;

	string names [NT];
	byte_t progs [NT][MAX_BYTES];
	int lens [NT];
	word_t check_addrs [NT];
	word_t expects [NT];
	int widths [NT];
	int n_tests = 0;
	int cycles = 0;
	int cycle_limit = 1000;
	int passes = 0;
	int fails = 0;

	f8_core UUT (.clk(clk), .reset(reset),
		.mem_read_addr_even(rd_addr_even), .mem_read_data_even(rd_data_even),
		.mem_write_addr_even(wr_addr_even), .mem_write_data_even(wr_data_even),
		.mem_write_en_even(wr_en_even),
		.mem_read_addr_odd(rd_addr_odd), .mem_read_data_odd(rd_data_odd),
		.mem_write_addr_odd(wr_addr_odd), .mem_write_data_odd(wr_data_odd),
		.mem_write_en_odd(wr_en_odd), .trap(trap));

	f8_tb_mem mem (.clk(clk), .rd_addr_even(rd_addr_even), .rd_addr_odd(rd_addr_odd),
		.rd_data_even(rd_data_even), .rd_data_odd(rd_data_odd),
		.wr_addr_even(wr_addr_even), .wr_addr_odd(wr_addr_odd),
		.wr_data_even(wr_data_even), .wr_data_odd(wr_data_odd),
		.wr_en_even(wr_en_even), .wr_en_odd(wr_en_odd));

	always #10 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit)
		begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	// program bytes are right aligned, first byte most significant
	task automatic add_test(input string name, input logic [8*MAX_BYTES-1:0] bytes,
		input int len, input word_t addr, input word_t exp, input int width);
		names[n_tests] = name;
		for (int k = 0; k < len; k++)
			progs[n_tests][k] = bytes[8*(len-1-k) +: 8];
		lens[n_tests] = len;
		check_addrs[n_tests] = addr;
		expects[n_tests] = exp;
		widths[n_tests] = width;
		n_tests++;
	endtask

	task automatic build_table();
		add_test("store even", {LD_XL_IMMD, 8'h5a, LD_DIR_XL, 8'h00, 8'h01, TRAP},
			6, 16'h0100, 16'h005a, 1);
		add_test("store odd", {LD_XL_IMMD, 8'ha5, LD_DIR_XL, 8'h03, 8'h01, TRAP},
			6, 16'h0103, 16'h00a5, 1);
		// 3c + c5 carries out of bit 7
		add_test("add imm", {LD_XL_IMMD, 8'h3c, ADD_XL_IMMD, 8'hc5, LD_DIR_XL, 8'h10, 8'h01,
			TRAP}, 8, 16'h0110, 16'h0001, 1);
		add_test("sub imm", {LD_XL_IMMD, 8'h10, SUB_XL_IMMD, 8'h20, LD_DIR_XL, 8'h11, 8'h01,
			TRAP}, 8, 16'h0111, 16'h00f0, 1);
		add_test("and imm", {LD_XL_IMMD, 8'hf0, AND_XL_IMMD, 8'h3c, LD_DIR_XL, 8'h12, 8'h01,
			TRAP}, 8, 16'h0112, 16'h0030, 1);
		add_test("or imm", {LD_XL_IMMD, 8'hf0, OR_XL_IMMD, 8'h0f, LD_DIR_XL, 8'h13, 8'h01,
			TRAP}, 8, 16'h0113, 16'h00ff, 1);
		add_test("xor imm", {LD_XL_IMMD, 8'haa, XOR_XL_IMMD, 8'hff, LD_DIR_XL, 8'h14, 8'h01,
			TRAP}, 8, 16'h0114, 16'h0055, 1);
		// xl cleared before the direct load
		add_test("load dir", {LD_XL_IMMD, 8'h3d, LD_DIR_XL, 8'h31, 8'h01, AND_XL_IMMD, 8'h00,
			LD_XL_DIR, 8'h31, 8'h01, LD_DIR_XL, 8'h32, 8'h01, TRAP},
			14, 16'h0132, 16'h003d, 1);
		add_test("add dir", {LD_XL_IMMD, 8'h27, LD_DIR_XL, 8'h21, 8'h01, ADD_XL_DIR, 8'h21,
			8'h01, LD_DIR_XL, 8'h22, 8'h01, TRAP}, 12, 16'h0122, 16'h004e, 1);
		// 12ff + 1 carries into the high byte
		add_test("word inc", {LDW_Y_IMMD, 8'hff, 8'h12, INCW_Y, LDW_DIR_Y, 8'h41, 8'h01, TRAP},
			8, 16'h0141, 16'h1300, 2);
		add_test("jrz taken", {LD_XL_IMMD, 8'h05, SUB_XL_IMMD, 8'h05, JRZ_D, 8'h04,
			LD_XL_IMMD, 8'hee, LD_DIR_XL, 8'h50, 8'h01, TRAP}, 12, 16'h0150, 16'h0000, 1);
		add_test("jrnz not taken", {LD_XL_IMMD, 8'h05, SUB_XL_IMMD, 8'h05, JRNZ_D, 8'h04,
			JR_D, 8'h04, LD_XL_IMMD, 8'hee, LD_DIR_XL, 8'h51, 8'h01, TRAP},
			14, 16'h0151, 16'h0000, 1);
		add_test("jrc taken", {LD_XL_IMMD, 8'hf0, ADD_XL_IMMD, 8'h20, JRC_D, 8'h04,
			LD_XL_IMMD, 8'hee, LD_DIR_XL, 8'h52, 8'h01, TRAP}, 12, 16'h0152, 16'h0010, 1);
		add_test("jrc not taken", {LD_XL_IMMD, 8'h10, ADD_XL_IMMD, 8'h20, JRC_D, 8'h04,
			JR_D, 8'h04, LD_XL_IMMD, 8'hee, LD_DIR_XL, 8'h53, 8'h01, TRAP},
			14, 16'h0153, 16'h0030, 1);
		// second jr goes back by six
		add_test("jr backward", {JR_D, 8'h06, LD_DIR_XL, 8'h54, 8'h01, TRAP, LD_XL_IMMD,
			8'h77, JR_D, 8'hfa}, 10, 16'h0154, 16'h0077, 1);
		add_test("trap only", {TRAP}, 1, 16'h0000, 16'h0000, 0);
	endtask

	task automatic run_test(input int t);
		int errs;
		int waited;
		int drops;
		int strobes;
		word_t got;
		byte_t neighbour;
		errs = 0;
		waited = 0;
		drops = 0;
		strobes = 0;
		@(posedge clk);
		reset <= 1'b1;
		mem.fill();
		for (int k = 0; k < lens[t]; k++)
			mem.load_byte(RESET_PC + word_t'(k), progs[t][k]);
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		while (!trap && waited < 3 * lens[t] + 10)
		begin
			@(negedge clk);
			waited++;
		end
		if (!trap)
		begin
			$display("%s: trap not seen within %0d cycles", names[t], waited);
			errs++;
		end
		else
		begin
			for (int k = 0; k < HOLD_CYCLES; k++)
			begin
				@(negedge clk);
				if (!trap)
					drops++;
				if (wr_en_even || wr_en_odd)
					strobes++;
			end
			if (drops != 0)
			begin
				$display("%s: trap went low in %0d cycles after TRAP", names[t], drops);
				errs++;
			end
			if (strobes != 0)
			begin
				$display("%s: write strobe seen in %0d cycles after TRAP", names[t], strobes);
				errs++;
			end
		end
		got = {mem.peek(check_addrs[t] + 16'd1), mem.peek(check_addrs[t])};
		// a byte store leaves the next byte at its fill value
		neighbour = mem.fill_byte(check_addrs[t] + 16'd1);
		if (widths[t] == 1 && got[7:0] != expects[t][7:0])
		begin
			$display("Mismatch mem[%h]: expected %h, actual %h", check_addrs[t],
				expects[t][7:0], got[7:0]);
			errs++;
		end
		if (widths[t] == 1 && got[15:8] != neighbour)
		begin
			$display("Mismatch mem[%h]: expected %h, actual %h", check_addrs[t] + 16'd1,
				neighbour, got[15:8]);
			errs++;
		end
		if (widths[t] == 2 && got != expects[t])
		begin
			$display("Mismatch mem[%h] word: expected %h, actual %h", check_addrs[t],
				expects[t], got);
			errs++;
		end
		if (errs == 0)
		begin
			passes++;
			$display("PASS %s", names[t]);
		end
		else
		begin
			fails++;
			$display("FAIL %s", names[t]);
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		build_table();
		cycle_limit = 0;
		for (int t = 0; t < n_tests; t++)
			cycle_limit += 3 * lens[t] + 10 + RESET_CYCLES + HOLD_CYCLES + 4;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("Tests passed: %0d, failed: %0d", passes, fails);
		if (fails == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: src.f
f8_pkg.sv
f8_alu.sv
f8_regfile.sv
f8_mem_lanes.sv
f8_fetch.sv
f8_execute.sv
f8_core.sv
f8_tb_mem.sv
f8_tb.sv
